/* verilog/rename_consts.svh */
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// register file sizes
`define NUM_ARCH_REG 16
`define NUM_PHYS_REG 32

// index widths, log2 of the counts above
`define ARCH_ID_W 4
`define PHYS_ID_W 5

// data and pc width
`define WORD_SIZE 32

// functional unit code of the branch unit
`define BRANCH_FU 3'd2

// opcode encodings the rename stage cares about
// unconditional branch
`define BX_OP 5'h10
// conditional branch
`define BCC_OP 5'h11
// store
`define STR_OP 5'h09

`endif

/* verilog/rename_isa_pkg.sv */
`include "rename_consts.svh"

package rename_isa_pkg;

  typedef logic [`ARCH_ID_W-1:0] arch_reg_t;
  typedef logic [`WORD_SIZE-1:0] word_t;

  typedef logic [4:0] opcode_t;
  typedef logic [2:0] func_unit_t;

  // instruction as handed over by the decoder
  typedef struct packed {
    word_t      pc;
    opcode_t    opcode;
    func_unit_t func_unit;
    logic [3:0] flags;
    logic [3:0] bcc_op;
    // source2_imm holds an immediate when set
    logic       imm;
    logic       w_v;
    arch_reg_t  dest_id;
    arch_reg_t  source_1;
    // immediate or architectural index in the low bits
    word_t      source2_imm;
  } decoded_instruction_t;

endpackage

/* verilog/rename_uop_pkg.sv */
`include "rename_consts.svh"

package rename_uop_pkg;

  import rename_isa_pkg::*;

  typedef logic [`PHYS_ID_W-1:0] phys_reg_t;

  // instruction after translation, sent to issue
  typedef struct packed {
    word_t      pc;
    opcode_t    opcode;
    func_unit_t func_unit;
    logic [3:0] flags;
    logic [3:0] bcc_op;
    logic       imm;
    logic       w_v;
    phys_reg_t  source_1;
    word_t      source2_imm;
    phys_reg_t  dest_id;
    // architectural destination
    arch_reg_t  alloc_reg;
    // previous physical mapping of alloc_reg
    phys_reg_t  freed_reg;
  } renamed_instruction_t;

  // new reorder buffer entry
  typedef struct packed {
    word_t      pc;
    logic       is_spec;
    logic       is_cond_branch;
    logic [3:0] bcc_op;
    logic [3:0] flag_mask;
    logic       is_store;
    logic       w_v;
    arch_reg_t  alloc_reg;
    phys_reg_t  freed_reg;
  } rename_rob_t;

  // record handed back by commit
  typedef struct packed {
    logic      w_v;
    arch_reg_t alloc_reg;
    phys_reg_t freed_reg;
  } commit_rename_t;

endpackage

/* verilog/rename_map_table.sv */
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_map_table
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  // lookup of the instruction being renamed
  input  rename_isa_pkg::arch_reg_t rd_src1_i,
  input  rename_isa_pkg::arch_reg_t rd_src2_i,
  input  rename_isa_pkg::arch_reg_t rd_dest_i,
  output rename_uop_pkg::phys_reg_t src1_phys_o,
  output rename_uop_pkg::phys_reg_t src2_phys_o,
  output rename_uop_pkg::phys_reg_t dest_old_o,
  // speculative update
  input  logic                   alloc_i,
  input  rename_uop_pkg::phys_reg_t alloc_phys_i,
  // committed update
  input  logic                   commit_i,
  input  rename_isa_pkg::arch_reg_t commit_arch_i,
  input  rename_uop_pkg::phys_reg_t commit_phys_i,
  input  logic                   rollback_i
);

  import rename_uop_pkg::*;

  phys_reg_t spec_map [`NUM_ARCH_REG];
  phys_reg_t com_map [`NUM_ARCH_REG];

  // lookups see the speculative state only
  assign src1_phys_o = spec_map[rd_src1_i];
  assign src2_phys_o = spec_map[rd_src2_i];
  assign dest_old_o  = spec_map[rd_dest_i];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      // identity mapping
      for (int i = 0; i < `NUM_ARCH_REG; i++)
      begin
        spec_map[i] <= phys_reg_t'(i);
        com_map[i]  <= phys_reg_t'(i);
      end
    end
    else
    begin
      if (rollback_i)
      begin
        spec_map <= com_map;
      end
      else if (alloc_i)
      begin
        spec_map[rd_dest_i] <= alloc_phys_i;
      end

      // mispredicted commit does not retire its own mapping
      if (commit_i && !rollback_i)
      begin
        com_map[commit_arch_i] <= commit_phys_i;
      end
    end
  end

endmodule

/* verilog/rename_free_list.sv */
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_free_list
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  // speculative allocation
  input  logic                      pop_i,
  output rename_uop_pkg::phys_reg_t head_o,
  output logic                      avail_o,
  // register freed by commit
  input  logic                      push_i,
  input  rename_uop_pkg::phys_reg_t push_phys_i,
  output rename_uop_pkg::phys_reg_t commit_head_o,
  input  logic                      rollback_i
);

  import rename_uop_pkg::*;

  localparam int CNT_W         = `PHYS_ID_W + 1;
  localparam int FREE_AT_RESET = `NUM_PHYS_REG - `NUM_ARCH_REG;

  // one slot per physical register, pointers wrap naturally
  phys_reg_t spec_buf [`NUM_PHYS_REG];
  phys_reg_t com_buf [`NUM_PHYS_REG];

  logic [`PHYS_ID_W-1:0] spec_rd, spec_wr;
  logic [`PHYS_ID_W-1:0] com_rd, com_wr;
  logic [CNT_W-1:0]      spec_cnt;

  assign head_o        = spec_buf[spec_rd];
  assign commit_head_o = com_buf[com_rd];
  assign avail_o       = (spec_cnt != '0);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      // registers above the architectural ones start free
      for (int i = 0; i < `NUM_PHYS_REG; i++)
      begin
        spec_buf[i] <= phys_reg_t'(i + `NUM_ARCH_REG);
        com_buf[i]  <= phys_reg_t'(i + `NUM_ARCH_REG);
      end
      spec_rd  <= '0;
      com_rd   <= '0;
      spec_wr  <= FREE_AT_RESET[`PHYS_ID_W-1:0];
      com_wr   <= FREE_AT_RESET[`PHYS_ID_W-1:0];
      spec_cnt <= FREE_AT_RESET[CNT_W-1:0];
    end
    else if (rollback_i)
    begin
      // back to the committed view, all non-architectural regs free again
      spec_buf <= com_buf;
      spec_rd  <= com_rd;
      spec_wr  <= com_wr;
      spec_cnt <= FREE_AT_RESET[CNT_W-1:0];
    end
    else
    begin
      if (pop_i)
        spec_rd <= spec_rd + 1'b1;

      if (push_i)
      begin
        spec_buf[spec_wr] <= push_phys_i;
        spec_wr           <= spec_wr + 1'b1;
        // committed side frees one and retires the oldest allocation
        com_buf[com_wr]   <= push_phys_i;
        com_wr            <= com_wr + 1'b1;
        com_rd            <= com_rd + 1'b1;
      end

      // push and pop together leave the count alone
      if (push_i && !pop_i)
        spec_cnt <= spec_cnt + 1'b1;
      else if (pop_i && !push_i)
        spec_cnt <= spec_cnt - 1'b1;
    end
  end

endmodule

/* verilog/rename_stage.sv */
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_stage
(
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // decoder side
  input  rename_isa_pkg::decoded_instruction_t decoded_i,
  input  logic                                 decoded_v_i,
  output logic                                 rename_decode_ready_o,
  // issue side
  output rename_uop_pkg::renamed_instruction_t renamed_o,
  output logic                                 renamed_v_o,
  input  logic                                 issue_rename_ready_i,
  // commit side
  input  logic                                 commit_v_i,
  input  rename_uop_pkg::commit_rename_t       commit_rename_i,
  input  logic                                 mispredict_i,
  // rob and store buffer
  input  logic                                 rob_ready_i,
  output rename_uop_pkg::rename_rob_t          rename_rob_o,
  output logic                                 rename_rob_v_o,
  output logic                                 rename_sb_v_o,
  // map table
  output rename_isa_pkg::arch_reg_t            map_src1_o,
  output rename_isa_pkg::arch_reg_t            map_src2_o,
  output rename_isa_pkg::arch_reg_t            map_dest_o,
  output rename_isa_pkg::arch_reg_t            commit_arch_o,
  input  rename_uop_pkg::phys_reg_t            map_src1_i,
  input  rename_uop_pkg::phys_reg_t            map_src2_i,
  input  rename_uop_pkg::phys_reg_t            map_dest_old_i,
  output logic                                 alloc_o,
  // free list
  output logic                                 push_o,
  output rename_uop_pkg::phys_reg_t            push_phys_o,
  output logic                                 rollback_o,
  input  rename_uop_pkg::phys_reg_t            fl_head_i,
  input  logic                                 fl_avail_i
);

  import rename_isa_pkg::*;
  import rename_uop_pkg::*;

  renamed_instruction_t renamed, renamed_r;
  logic                 renamed_v_r;
  logic                 accept;
  logic                 is_branch;

  // commit record fanned out to both tables
  assign rollback_o    = commit_v_i & mispredict_i;
  assign push_o        = commit_v_i & commit_rename_i.w_v;
  assign push_phys_o   = commit_rename_i.freed_reg;
  assign commit_arch_o = commit_rename_i.alloc_reg;

  assign rename_decode_ready_o = fl_avail_i && !rollback_o && issue_rename_ready_i && rob_ready_i;
  assign accept                = decoded_v_i & rename_decode_ready_o;
  assign alloc_o               = accept & decoded_i.w_v;

  assign map_src1_o = decoded_i.source_1;
  assign map_src2_o = decoded_i.source2_imm[`ARCH_ID_W-1:0];
  assign map_dest_o = decoded_i.dest_id;

  always_comb
  begin
    renamed.pc        = decoded_i.pc;
    renamed.opcode    = decoded_i.opcode;
    renamed.func_unit = decoded_i.func_unit;
    renamed.flags     = decoded_i.flags;
    renamed.bcc_op    = decoded_i.bcc_op;
    renamed.imm       = decoded_i.imm;
    renamed.w_v       = decoded_i.w_v;
    renamed.source_1  = map_src1_i;
    // immediates pass through untouched
    renamed.source2_imm = decoded_i.imm ? decoded_i.source2_imm : word_t'(map_src2_i);
    renamed.dest_id   = decoded_i.w_v ? fl_head_i : phys_reg_t'(decoded_i.dest_id);
    renamed.alloc_reg = decoded_i.dest_id;
    renamed.freed_reg = map_dest_old_i;
  end

  // rob entry, branch and store classification
  assign is_branch = (decoded_i.func_unit == `BRANCH_FU);

  assign rename_rob_o.pc             = decoded_i.pc;
  assign rename_rob_o.is_spec        = is_branch &&
                                       (decoded_i.opcode == `BX_OP ||
                                        decoded_i.opcode == `BCC_OP);
  assign rename_rob_o.is_cond_branch = is_branch && (decoded_i.opcode == `BCC_OP);
  assign rename_rob_o.bcc_op         = decoded_i.bcc_op;
  assign rename_rob_o.flag_mask      = decoded_i.flags;
  assign rename_rob_o.is_store       = (decoded_i.opcode == `STR_OP);
  assign rename_rob_o.w_v            = decoded_i.w_v;
  assign rename_rob_o.alloc_reg      = decoded_i.dest_id;
  assign rename_rob_o.freed_reg      = map_dest_old_i;

  assign rename_rob_v_o = accept;
  assign rename_sb_v_o  = accept & rename_rob_o.is_store;

  // issue output register, holds while issue stalls
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      renamed_r   <= '0;
      renamed_v_r <= 1'b0;
    end
    else if (issue_rename_ready_i)
    begin
      renamed_r   <= renamed;
      renamed_v_r <= accept;
    end
  end

  assign renamed_o   = renamed_r;
  assign renamed_v_o = renamed_v_r;

endmodule

/* verilog/rename_unit.sv */
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_unit
(
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  rename_isa_pkg::decoded_instruction_t decoded_i,
  input  logic                                 decoded_v_i,
  output logic                                 rename_decode_ready_o,
  output rename_uop_pkg::renamed_instruction_t renamed_o,
  output logic                                 renamed_v_o,
  input  logic                                 issue_rename_ready_i,
  input  logic                                 commit_v_i,
  input  rename_uop_pkg::commit_rename_t       commit_rename_i,
  input  logic                                 mispredict_i,
  input  logic                                 rob_ready_i,
  output rename_uop_pkg::rename_rob_t          rename_rob_o,
  output logic                                 rename_rob_v_o,
  output logic                                 rename_sb_v_o
);

  import rename_isa_pkg::*;
  import rename_uop_pkg::*;

  // map table lookups
  arch_reg_t map_src1, map_src2, map_dest, commit_arch;
  phys_reg_t src1_phys, src2_phys, dest_old;

  // free list and commit path
  phys_reg_t fl_head, commit_head, push_phys;
  logic      fl_avail, alloc, push, rollback;

  rename_stage i_rename_stage (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .decoded_i             (decoded_i),
    .decoded_v_i           (decoded_v_i),
    .rename_decode_ready_o (rename_decode_ready_o),
    .renamed_o             (renamed_o),
    .renamed_v_o           (renamed_v_o),
    .issue_rename_ready_i  (issue_rename_ready_i),
    .commit_v_i            (commit_v_i),
    .commit_rename_i       (commit_rename_i),
    .mispredict_i          (mispredict_i),
    .rob_ready_i           (rob_ready_i),
    .rename_rob_o          (rename_rob_o),
    .rename_rob_v_o        (rename_rob_v_o),
    .rename_sb_v_o         (rename_sb_v_o),
    .map_src1_o            (map_src1),
    .map_src2_o            (map_src2),
    .map_dest_o            (map_dest),
    .commit_arch_o         (commit_arch),
    .map_src1_i            (src1_phys),
    .map_src2_i            (src2_phys),
    .map_dest_old_i        (dest_old),
    .alloc_o               (alloc),
    .push_o                (push),
    .push_phys_o           (push_phys),
    .rollback_o            (rollback),
    .fl_head_i             (fl_head),
    .fl_avail_i            (fl_avail)
  );

  rename_map_table i_rename_map_table (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rd_src1_i     (map_src1),
    .rd_src2_i     (map_src2),
    .rd_dest_i     (map_dest),
    .src1_phys_o   (src1_phys),
    .src2_phys_o   (src2_phys),
    .dest_old_o    (dest_old),
    .alloc_i       (alloc),
    .alloc_phys_i  (fl_head),
    .commit_i      (push),
    .commit_arch_i (commit_arch),
    .commit_phys_i (commit_head),
    .rollback_i    (rollback)
  );

  rename_free_list i_rename_free_list (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .pop_i         (alloc),
    .head_o        (fl_head),
    .avail_o       (fl_avail),
    .push_i        (push),
    .push_phys_i   (push_phys),
    .commit_head_o (commit_head),
    .rollback_i    (rollback)
  );

endmodule

/* verification/rename_unit_checker.sv */
`timescale 1ns/1ps

module rename_unit_checker
(
  input logic                                 clk_i,
  input logic                                 reset_i,
  input logic                                 decoded_v_i,
  input logic                                 issue_rename_ready_i,
  input rename_uop_pkg::renamed_instruction_t renamed_o,
  input logic                                 renamed_v_o,
  input logic                                 rename_rob_v_o,
  input logic                                 rename_sb_v_o
);

  // number of failed assertions so far
  int fail_count = 0;

  sb_implies_rob: assert property (@(posedge clk_i) disable iff (reset_i)
    rename_sb_v_o |-> rename_rob_v_o)
    else
    begin
      fail_count++;
      $error("store buffer strobe without a rob strobe");
    end

  rob_implies_decode: assert property (@(posedge clk_i) disable iff (reset_i)
    rename_rob_v_o |-> decoded_v_i)
    else
    begin
      fail_count++;
      $error("rob strobe without a valid decoded instruction");
    end

  // issue stall freezes the output register
  hold_on_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    !issue_rename_ready_i |=> $stable(renamed_o) && $stable(renamed_v_o))
    else
    begin
      fail_count++;
      $error("renamed output changed while issue was stalled");
    end

  low_in_reset: assert property (@(posedge clk_i)
    reset_i |=> !renamed_v_o)
    else
    begin
      fail_count++;
      $error("renamed_v_o high after a reset cycle");
    end

endmodule

bind rename_unit rename_unit_checker i_rename_unit_checker
(
  .clk_i                (clk_i),
  .reset_i              (reset_i),
  .decoded_v_i          (decoded_v_i),
  .issue_rename_ready_i (issue_rename_ready_i),
  .renamed_o            (renamed_o),
  .renamed_v_o          (renamed_v_o),
  .rename_rob_v_o       (rename_rob_v_o),
  .rename_sb_v_o        (rename_sb_v_o)
);

/* verification/rename_unit_tb.sv */
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_unit_tb;

  import rename_isa_pkg::*;
  import rename_uop_pkg::*;

  localparam int         MAX_WAIT = 50;
  localparam opcode_t    ALU_OP   = 5'h01;
  localparam func_unit_t ALU_FU   = 3'd0;
  localparam func_unit_t MEM_FU   = 3'd1;

  logic                 clk_i;
  logic                 reset_i;
  decoded_instruction_t decoded_i;
  logic                 decoded_v_i;
  logic                 rename_decode_ready_o;
  renamed_instruction_t renamed_o;
  logic                 renamed_v_o;
  logic                 issue_rename_ready_i;
  logic                 commit_v_i;
  commit_rename_t       commit_rename_i;
  logic                 mispredict_i;
  logic                 rob_ready_i;
  rename_rob_t          rename_rob_o;
  logic                 rename_rob_v_o;
  logic                 rename_sb_v_o;

  // reference model
  phys_reg_t      spec_map [`NUM_ARCH_REG];
  phys_reg_t      com_map [`NUM_ARCH_REG];
  phys_reg_t      spec_free [$];
  phys_reg_t      com_free [$];
  commit_rename_t in_flight [$];

  integer seed;
  word_t  pc_count;

  rename_unit i_rename_unit (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_renamed(string name, renamed_instruction_t exp, renamed_instruction_t act);
    if (act !== exp)
    begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_rob(string name, rename_rob_t exp, rename_rob_t act);
    if (act !== exp)
    begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp)
    begin
      $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  always @(posedge clk_i)
  begin
    if (i_rename_unit.i_rename_unit_checker.fail_count != 0)
    begin
      $display("an assertion bound to rename_unit failed");
      stop_run();
    end
  end

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic decoded_instruction_t make_instr(opcode_t op, func_unit_t fu, logic w_v,
      arch_reg_t dest, arch_reg_t src1, logic imm, word_t src2);
    decoded_instruction_t d;
    d.pc          = pc_count;
    d.opcode      = op;
    d.func_unit   = fu;
    d.flags       = 4'h5;
    d.bcc_op      = (op == `BCC_OP) ? 4'h2 : 4'h0;
    d.imm         = imm;
    d.w_v         = w_v;
    d.dest_id     = dest;
    d.source_1    = src1;
    d.source2_imm = src2;
    pc_count      = pc_count + 4;
    return d;
  endfunction

  function automatic void reset_model();
    spec_free.delete();
    com_free.delete();
    in_flight.delete();
    for (int i = 0; i < `NUM_ARCH_REG; i++)
    begin
      spec_map[i] = phys_reg_t'(i);
      com_map[i]  = phys_reg_t'(i);
    end
    // registers above the architectural range start free, in order
    for (int i = `NUM_ARCH_REG; i < `NUM_PHYS_REG; i++)
    begin
      spec_free.push_back(phys_reg_t'(i));
      com_free.push_back(phys_reg_t'(i));
    end
  endfunction

  function automatic renamed_instruction_t predict_renamed(decoded_instruction_t d);
    renamed_instruction_t r;
    r.pc        = d.pc;
    r.opcode    = d.opcode;
    r.func_unit = d.func_unit;
    r.flags     = d.flags;
    r.bcc_op    = d.bcc_op;
    r.imm       = d.imm;
    r.w_v       = d.w_v;
    r.source_1  = spec_map[d.source_1];
    if (d.imm)
      r.source2_imm = d.source2_imm;
    else
      r.source2_imm = word_t'(spec_map[d.source2_imm[`ARCH_ID_W-1:0]]);
    r.dest_id   = d.w_v ? spec_free[0] : phys_reg_t'(d.dest_id);
    r.alloc_reg = d.dest_id;
    r.freed_reg = spec_map[d.dest_id];
    return r;
  endfunction

  function automatic rename_rob_t rob_entry_for(decoded_instruction_t d);
    rename_rob_t e;
    logic        branch;
    branch           = (d.func_unit == `BRANCH_FU);
    e.pc             = d.pc;
    e.is_spec        = branch && (d.opcode == `BX_OP || d.opcode == `BCC_OP);
    e.is_cond_branch = branch && (d.opcode == `BCC_OP);
    e.bcc_op         = d.bcc_op;
    e.flag_mask      = d.flags;
    e.is_store       = (d.opcode == `STR_OP);
    e.w_v            = d.w_v;
    e.alloc_reg      = d.dest_id;
    e.freed_reg      = spec_map[d.dest_id];
    return e;
  endfunction

  function automatic void accept_in_model(decoded_instruction_t d);
    commit_rename_t rec;
    if (d.w_v)
    begin
      rec.w_v            = 1'b1;
      rec.alloc_reg      = d.dest_id;
      rec.freed_reg      = spec_map[d.dest_id];
      spec_map[d.dest_id] = spec_free.pop_front();
      in_flight.push_back(rec);
    end
  endfunction

  task automatic apply_reset();
    @(posedge clk_i);
    #1;
    reset_i = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    reset_model();
  endtask

  // offer one instruction, wait for acceptance, check rob and issue sides
  task automatic rename_one(decoded_instruction_t d);
    renamed_instruction_t exp_ren;
    int                   waited;
    waited = 0;
    @(posedge clk_i);
    #1;
    decoded_i   = d;
    decoded_v_i = 1'b1;
    @(negedge clk_i);
    while (!rename_decode_ready_o)
    begin
      waited++;
      if (waited >= MAX_WAIT)
      begin
        $display("timeout: rename_decode_ready_o stayed low for %0d cycles", MAX_WAIT);
        stop_run();
      end
      @(negedge clk_i);
    end
    exp_ren = predict_renamed(d);
    check_bit("rename_rob_v_o", 1'b1, rename_rob_v_o);
    check_bit("rename_sb_v_o", d.opcode == `STR_OP, rename_sb_v_o);
    check_rob("rename_rob_o", rob_entry_for(d), rename_rob_o);
    check_bit("renamed_v_o", 1'b0, renamed_v_o);
    accept_in_model(d);
    @(posedge clk_i);
    #1;
    decoded_v_i = 1'b0;
    @(negedge clk_i);
    check_bit("renamed_v_o", 1'b1, renamed_v_o);
    check_renamed("renamed_o", exp_ren, renamed_o);
    check_bit("rename_rob_v_o", 1'b0, rename_rob_v_o);
    check_bit("rename_sb_v_o", 1'b0, rename_sb_v_o);
  endtask

  task automatic commit_oldest();
    commit_rename_t rec;
    if (in_flight.size() == 0)
    begin
      $display("no renamed writer left to commit");
      stop_run();
    end
    rec = in_flight.pop_front();
    @(posedge clk_i);
    #1;
    commit_v_i      = 1'b1;
    commit_rename_i = rec;
    // committed map takes the oldest allocation
    com_map[rec.alloc_reg] = com_free.pop_front();
    com_free.push_back(rec.freed_reg);
    spec_free.push_back(rec.freed_reg);
    @(posedge clk_i);
    #1;
    commit_v_i = 1'b0;
  endtask

  // mispredicted branch commit, writes no register
  task automatic flush_mispredict();
    @(posedge clk_i);
    #1;
    commit_v_i      = 1'b1;
    mispredict_i    = 1'b1;
    commit_rename_i = '0;
    @(negedge clk_i);
    check_bit("rename_decode_ready_o", 1'b0, rename_decode_ready_o);
    spec_map  = com_map;
    spec_free = com_free;
    in_flight.delete();
    @(posedge clk_i);
    #1;
    commit_v_i   = 1'b0;
    mispredict_i = 1'b0;
    @(negedge clk_i);
    check_bit("rename_decode_ready_o", 1'b1, rename_decode_ready_o);
  endtask

  task automatic write_many(int n);
    for (int i = 0; i < n; i++)
      rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, arch_reg_t'(i), arch_reg_t'(i), 1'b1,
                            rand_word()));
  endtask

  task automatic check_stalled();
    @(posedge clk_i);
    #1;
    decoded_i   = make_instr(ALU_OP, ALU_FU, 1'b1, 4'd9, 4'd9, 1'b1, rand_word());
    decoded_v_i = 1'b1;
    @(negedge clk_i);
    check_bit("rename_decode_ready_o", 1'b0, rename_decode_ready_o);
    check_bit("rename_rob_v_o", 1'b0, rename_rob_v_o);
    @(posedge clk_i);
    #1;
    decoded_v_i = 1'b0;
  endtask

  task automatic identity_after_reset();
    apply_reset();
    @(negedge clk_i);
    check_bit("renamed_v_o", 1'b0, renamed_v_o);
    check_bit("rename_rob_v_o", 1'b0, rename_rob_v_o);
    check_bit("rename_sb_v_o", 1'b0, rename_sb_v_o);
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd3, 4'd3, 1'b0, 32'd5));
  endtask

  task automatic dependency_chain();
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd7, 4'd7, 1'b1, rand_word()));
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b0, 4'd0, 4'd7, 1'b0, 32'd7));
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd7, 4'd7, 1'b0, 32'd3));
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd7, 4'd3, 1'b1, rand_word()));
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b0, 4'd0, 4'd3, 1'b0, 32'd7));
  endtask

  task automatic classify_ops();
    rename_one(make_instr(`STR_OP, MEM_FU, 1'b0, 4'd0, 4'd2, 1'b1, rand_word()));
    rename_one(make_instr(`BCC_OP, `BRANCH_FU, 1'b0, 4'd0, 4'd0, 1'b1, rand_word()));
    rename_one(make_instr(`BX_OP, `BRANCH_FU, 1'b0, 4'd0, 4'd0, 1'b1, rand_word()));
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd4, 4'd4, 1'b1, rand_word()));
  endtask

  task automatic backpressure();
    decoded_instruction_t a;
    decoded_instruction_t b;
    renamed_instruction_t exp_a;
    renamed_instruction_t exp_b;
    a = make_instr(ALU_OP, ALU_FU, 1'b1, 4'd5, 4'd5, 1'b1, rand_word());
    b = make_instr(ALU_OP, ALU_FU, 1'b1, 4'd6, 4'd5, 1'b0, 32'd3);
    @(posedge clk_i);
    #1;
    decoded_i   = a;
    decoded_v_i = 1'b1;
    @(negedge clk_i);
    check_bit("rename_decode_ready_o", 1'b1, rename_decode_ready_o);
    exp_a = predict_renamed(a);
    accept_in_model(a);
    @(posedge clk_i);
    #1;
    issue_rename_ready_i = 1'b0;
    decoded_i            = b;
    for (int i = 0; i < 3; i++)
    begin
      @(negedge clk_i);
      check_bit("rename_decode_ready_o", 1'b0, rename_decode_ready_o);
      check_bit("rename_rob_v_o", 1'b0, rename_rob_v_o);
      check_bit("renamed_v_o", 1'b1, renamed_v_o);
      check_renamed("renamed_o", exp_a, renamed_o);
    end
    @(posedge clk_i);
    #1;
    issue_rename_ready_i = 1'b1;
    @(negedge clk_i);
    check_bit("rename_decode_ready_o", 1'b1, rename_decode_ready_o);
    check_renamed("renamed_o", exp_a, renamed_o);
    exp_b = predict_renamed(b);
    accept_in_model(b);
    @(posedge clk_i);
    #1;
    decoded_v_i = 1'b0;
    @(negedge clk_i);
    check_bit("renamed_v_o", 1'b1, renamed_v_o);
    check_renamed("renamed_o", exp_b, renamed_o);
    // rob full
    @(posedge clk_i);
    #1;
    rob_ready_i = 1'b0;
    @(negedge clk_i);
    check_bit("rename_decode_ready_o", 1'b0, rename_decode_ready_o);
    @(posedge clk_i);
    #1;
    rob_ready_i = 1'b1;
    @(negedge clk_i);
    check_bit("rename_decode_ready_o", 1'b1, rename_decode_ready_o);
  endtask

  task automatic exhaustion_and_free();
    apply_reset();
    write_many(16);
    check_stalled();
    commit_oldest();
    @(negedge clk_i);
    check_bit("rename_decode_ready_o", 1'b1, rename_decode_ready_o);
    // next writer picks up the register just freed
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd9, 4'd9, 1'b1, rand_word()));
  endtask

  task automatic rollback_restore();
    apply_reset();
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd1, 4'd1, 1'b1, rand_word()));
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd2, 4'd1, 1'b0, 32'd1));
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd1, 4'd2, 1'b1, rand_word()));
    commit_oldest();
    commit_oldest();
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd2, 4'd1, 1'b0, 32'd2));
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b1, 4'd3, 4'd3, 1'b1, rand_word()));
    flush_mispredict();
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b0, 4'd0, 4'd1, 1'b0, 32'd2));
    rename_one(make_instr(ALU_OP, ALU_FU, 1'b0, 4'd0, 4'd3, 1'b0, 32'd0));
    // full free list again after the flush
    write_many(16);
    check_stalled();
  endtask

  initial
  begin
    seed                 = 32'h4e98;
    pc_count             = 32'h0000_1000;
    reset_i              = 1'b1;
    decoded_i            = '0;
    decoded_v_i          = 1'b0;
    issue_rename_ready_i = 1'b1;
    commit_v_i           = 1'b0;
    commit_rename_i      = '0;
    mispredict_i         = 1'b0;
    rob_ready_i          = 1'b1;

    identity_after_reset();
    dependency_chain();
    classify_ops();
    backpressure();
    exhaustion_and_free();
    rollback_restore();

    @(negedge clk_i);
    if (i_rename_unit.i_rename_unit_checker.fail_count == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
    begin
      $display("assertions bound to rename_unit failed during the run");
      stop_run();
    end
  end

endmodule

/* tb.f */
+incdir+verilog
verilog/rename_isa_pkg.sv
verilog/rename_uop_pkg.sv
verilog/rename_map_table.sv
verilog/rename_free_list.sv
verilog/rename_stage.sv
verilog/rename_unit.sv
verification/rename_unit_checker.sv
verification/rename_unit_tb.sv
